// File: verilog/hsd_cfg.svh
`ifndef HSD_CFG_SVH
`define HSD_CFG_SVH

// Sample stream geometry
`define HSD_ADC_WIDTH          12
`define HSD_LANE_WIDTH         16
`define HSD_SAMPLES_PER_CLOCK  2
`define HSD_CHANNEL_COUNT      2
`define HSD_BUFFER_DEPTH       64
`define HSD_TRIGGER_WIDTH      7

// Timekeeping defaults
`define HSD_TICKS_PER_US       100
`define HSD_US_PER_SECOND      1000000

// Host register interface
`define HSD_REG_ADDR_WIDTH     5
`define HSD_REG_DATA_WIDTH     32
`define HSD_FIRMWARE_ID        32'h4853_4431

// Register map
`define HSD_REG_ID             5'd0
`define HSD_REG_MICROSECONDS   5'd1
`define HSD_REG_SECONDS        5'd2
`define HSD_REG_TRIGGER        5'd3
`define HSD_REG_ACQ_CSR        5'd4
`define HSD_REG_ACQ_DATA       5'd5
`define HSD_REG_ACQ_TIMESTAMP  5'd6
`define HSD_REG_RANGE_CLEAR    5'd7
`define HSD_REG_RANGE_BASE     5'd8

`endif

// File: verilog/hsdPkg.sv
`include "hsd_cfg.svh"

package hsdPkg;

    ////////////////////
    // Host register words
    typedef logic [`HSD_REG_ADDR_WIDTH-1:0] regAddrT;
    typedef logic [`HSD_REG_DATA_WIDTH-1:0] regWordT;

    ////////////////////
    // ADC samples
    // Lane 0 in the low bits, code left-justified in each lane
    typedef logic [`HSD_SAMPLES_PER_CLOCK*`HSD_LANE_WIDTH-1:0] sampleWordT;
    typedef logic signed [`HSD_ADC_WIDTH-1:0] sampleT;

    // Bit 0 is the software trigger
    typedef logic [`HSD_TRIGGER_WIDTH-1:0] triggerBusT;

    typedef logic [$clog2(`HSD_BUFFER_DEPTH)-1:0] bufAddrT;

    typedef enum logic [1:0] {
        ACQ_IDLE    = 2'd0,
        ACQ_ARMED   = 2'd1,
        ACQ_CAPTURE = 2'd2,
        ACQ_DONE    = 2'd3
    } acqStateT;

endpackage

// File: verilog/regBank.sv
`timescale 1ns/100ps
`include "hsd_cfg.svh"

module regBank (
    input  logic            sysClk,
    input  logic            arstN,
    input  logic            regValid,
    output logic            regReady,
    input  logic            regWrite,
    input  hsdPkg::regAddrT regAddr,
    input  hsdPkg::regWordT regWdata,
    output logic            rspValid,
    output hsdPkg::regWordT rspData,
    output logic            triggerWrite,
    output logic            acqCsrWrite,
    output logic            acqDataWrite,
    output logic            acqDataRead,
    output logic            rangeClearWrite,
    output hsdPkg::regWordT wrData,
    input  hsdPkg::regWordT microseconds,
    input  hsdPkg::regWordT seconds,
    input  hsdPkg::regWordT triggerMask,
    input  hsdPkg::regWordT acqStatus,
    input  hsdPkg::regWordT acqData,
    input  hsdPkg::regWordT acqTimestamp,
    input  hsdPkg::regWordT rangeWords [`HSD_CHANNEL_COUNT]
);

    logic            accept;
    logic            writeAccept;
    logic            readAccept;
    logic            rspIsData;
    hsdPkg::regWordT readWord;
    hsdPkg::regWordT rspWord;

    // At most one read response in flight
    assign regReady    = ~rspValid;
    assign accept      = regValid & regReady;
    assign writeAccept = accept & regWrite;
    assign readAccept  = accept & ~regWrite;

    // Buffer memory is read on the accepting edge
    assign acqDataRead = readAccept && (regAddr == `HSD_REG_ACQ_DATA);

    ////////////////////
    // Write strobes
    always_ff @(posedge sysClk or negedge arstN) begin
        if (!arstN) begin
            triggerWrite    <= 1'b0;
            acqCsrWrite     <= 1'b0;
            acqDataWrite    <= 1'b0;
            rangeClearWrite <= 1'b0;
        end else begin
            triggerWrite    <= writeAccept && (regAddr == `HSD_REG_TRIGGER);
            acqCsrWrite     <= writeAccept && (regAddr == `HSD_REG_ACQ_CSR);
            acqDataWrite    <= writeAccept && (regAddr == `HSD_REG_ACQ_DATA);
            rangeClearWrite <= writeAccept && (regAddr == `HSD_REG_RANGE_CLEAR);
        end
    end

    always_ff @(posedge sysClk) begin
        if (writeAccept) begin
            wrData <= regWdata;
        end
    end

    ////////////////////
    // Read path
    always_comb begin
        readWord = '0;
        case (regAddr)
            `HSD_REG_ID:            readWord = `HSD_FIRMWARE_ID;
            `HSD_REG_MICROSECONDS:  readWord = microseconds;
            `HSD_REG_SECONDS:       readWord = seconds;
            `HSD_REG_TRIGGER:       readWord = triggerMask;
            `HSD_REG_ACQ_CSR:       readWord = acqStatus;
            `HSD_REG_ACQ_TIMESTAMP: readWord = acqTimestamp;
            default: begin
                // One range word per channel
                for (int c = 0; c < `HSD_CHANNEL_COUNT; c++) begin
                    if (regAddr == hsdPkg::regAddrT'(`HSD_REG_RANGE_BASE + c)) begin
                        readWord = rangeWords[c];
                    end
                end
            end
        endcase
    end

    always_ff @(posedge sysClk or negedge arstN) begin
        if (!arstN) begin
            rspValid  <= 1'b0;
            rspIsData <= 1'b0;
        end else begin
            rspValid  <= readAccept;
            rspIsData <= acqDataRead;
        end
    end

    always_ff @(posedge sysClk) begin
        if (readAccept) begin
            rspWord <= readWord;
        end
    end

    // Buffer words come from the memory output register
    assign rspData = rspIsData ? acqData : rspWord;

endmodule

// File: verilog/timeKeeper.sv
`timescale 1ns/100ps
`include "hsd_cfg.svh"

module timeKeeper #(
    parameter int ticksPerMicrosecond   = `HSD_TICKS_PER_US,
    parameter int microsecondsPerSecond = `HSD_US_PER_SECOND
) (
    input  logic            sysClk,
    input  logic            arstN,
    output hsdPkg::regWordT microseconds,
    output hsdPkg::regWordT seconds
);

    hsdPkg::regWordT tickCount;
    hsdPkg::regWordT usInSecond;
    logic            usTick;

    assign usTick = (tickCount == hsdPkg::regWordT'(ticksPerMicrosecond - 1));

    // Microsecond prescaler
    always_ff @(posedge sysClk or negedge arstN) begin
        if (!arstN) begin
            tickCount <= '0;
        end else if (usTick) begin
            tickCount <= '0;
        end else begin
            tickCount <= tickCount + 1'b1;
        end
    end

    // Microseconds keep counting since boot, usInSecond marks whole seconds
    always_ff @(posedge sysClk or negedge arstN) begin
        if (!arstN) begin
            microseconds <= '0;
            usInSecond   <= '0;
            seconds      <= '0;
        end else if (usTick) begin
            microseconds <= microseconds + 1'b1;
            if (usInSecond == hsdPkg::regWordT'(microsecondsPerSecond - 1)) begin
                usInSecond <= '0;
                seconds    <= seconds + 1'b1;
            end else begin
                usInSecond <= usInSecond + 1'b1;
            end
        end
    end

endmodule

// File: verilog/triggerSelect.sv
`timescale 1ns/100ps
`include "hsd_cfg.svh"

module triggerSelect (
    input  logic                          sysClk,
    input  logic                          arstN,
    input  logic [`HSD_TRIGGER_WIDTH-2:0] eventTriggers,
    input  logic                          triggerWrite,
    input  hsdPkg::regWordT               wrData,
    output hsdPkg::regWordT               triggerMask,
    output logic                          acqTrigger
);

    logic [`HSD_TRIGGER_WIDTH-2:0] eventMeta;
    logic [`HSD_TRIGGER_WIDTH-2:0] eventSync;
    logic [`HSD_TRIGGER_WIDTH-2:0] eventPrev;
    logic                          softTrigger;
    hsdPkg::triggerBusT            sourceStrobes;
    hsdPkg::triggerBusT            enableMask;

    ////////////////////
    // Event trigger synchronizer and edge detect
    always_ff @(posedge sysClk or negedge arstN) begin
        if (!arstN) begin
            eventMeta <= '0;
            eventSync <= '0;
            eventPrev <= '0;
        end else begin
            eventMeta <= eventTriggers;
            eventSync <= eventMeta;
            eventPrev <= eventSync;
        end
    end

    // Single clock domain, so the software strobe is used as is
    assign softTrigger   = triggerWrite & wrData[0];
    assign sourceStrobes = {eventSync & ~eventPrev, softTrigger};

    ////////////////////
    // Enable mask and trigger output
    always_ff @(posedge sysClk or negedge arstN) begin
        if (!arstN) begin
            enableMask <= '0;
            acqTrigger <= 1'b0;
        end else begin
            if (triggerWrite) begin
                enableMask <= wrData[1 +: `HSD_TRIGGER_WIDTH];
            end
            acqTrigger <= |(sourceStrobes & enableMask);
        end
    end

    // Mask reads back in the bits it was written to
    assign triggerMask = {{(`HSD_REG_DATA_WIDTH-`HSD_TRIGGER_WIDTH-1){1'b0}},
                          enableMask, 1'b0};

endmodule

// File: verilog/rangeCheck.sv
`timescale 1ns/100ps
`include "hsd_cfg.svh"

module rangeCheck (
    input  logic               sysClk,
    input  logic               arstN,
    input  hsdPkg::sampleWordT samples [`HSD_CHANNEL_COUNT],
    input  logic               samplesValid,
    input  logic               rangeClearWrite,
    output hsdPkg::regWordT    rangeWords [`HSD_CHANNEL_COUNT]
);

    localparam int halfWidth = `HSD_REG_DATA_WIDTH / 2;
    localparam int codeLsb   = `HSD_LANE_WIDTH - `HSD_ADC_WIDTH;

    // Cleared trackers start inverted so any sample replaces them
    localparam hsdPkg::sampleT codeMax = {1'b0, {(`HSD_ADC_WIDTH-1){1'b1}}};
    localparam hsdPkg::sampleT codeMin = {1'b1, {(`HSD_ADC_WIDTH-1){1'b0}}};

    for (genvar ch = 0; ch < `HSD_CHANNEL_COUNT; ch++) begin : chanTrack
        hsdPkg::sampleT wordMin;
        hsdPkg::sampleT wordMax;
        hsdPkg::sampleT rangeMin;
        hsdPkg::sampleT rangeMax;

        // Lane extremes of the current word
        always_comb begin
            hsdPkg::sampleT code;
            wordMin = codeMax;
            wordMax = codeMin;
            for (int lane = 0; lane < `HSD_SAMPLES_PER_CLOCK; lane++) begin
                code = samples[ch][lane*`HSD_LANE_WIDTH + codeLsb +: `HSD_ADC_WIDTH];
                if (code < wordMin) begin
                    wordMin = code;
                end
                if (code > wordMax) begin
                    wordMax = code;
                end
            end
        end

        always_ff @(posedge sysClk or negedge arstN) begin
            if (!arstN) begin
                rangeMin <= codeMax;
                rangeMax <= codeMin;
            end else if (rangeClearWrite) begin
                rangeMin <= codeMax;
                rangeMax <= codeMin;
            end else if (samplesValid) begin
                if (wordMin < rangeMin) begin
                    rangeMin <= wordMin;
                end
                if (wordMax > rangeMax) begin
                    rangeMax <= wordMax;
                end
            end
        end

        // Max in the upper half, min in the lower half
        assign rangeWords[ch] = {
            {(halfWidth-`HSD_ADC_WIDTH){rangeMax[`HSD_ADC_WIDTH-1]}}, rangeMax,
            {(halfWidth-`HSD_ADC_WIDTH){rangeMin[`HSD_ADC_WIDTH-1]}}, rangeMin};
    end

endmodule

// File: verilog/acqBuffer.sv
`timescale 1ns/100ps
`include "hsd_cfg.svh"

module acqBuffer (
    input  logic               sysClk,
    input  logic               arstN,
    input  hsdPkg::sampleWordT samples [`HSD_CHANNEL_COUNT],
    input  logic               samplesValid,
    input  logic               acqTrigger,
    input  logic               acqCsrWrite,
    input  logic               acqDataWrite,
    input  logic               acqDataRead,
    input  hsdPkg::regWordT    wrData,
    input  hsdPkg::regWordT    microseconds,
    output hsdPkg::regWordT    acqStatus,
    output hsdPkg::regWordT    acqData,
    output hsdPkg::regWordT    acqTimestamp
);

    localparam int selWidth = ($clog2(`HSD_CHANNEL_COUNT) > 0) ?
                              $clog2(`HSD_CHANNEL_COUNT) : 1;
    localparam int addrWidth = $bits(hsdPkg::bufAddrT);
    localparam hsdPkg::bufAddrT lastIndex = hsdPkg::bufAddrT'(`HSD_BUFFER_DEPTH - 1);

    hsdPkg::acqStateT    state;
    logic [selWidth-1:0] chanSel;
    hsdPkg::bufAddrT     writeIdx;
    hsdPkg::bufAddrT     readPtr;
    hsdPkg::bufAddrT     readAddr;
    hsdPkg::sampleWordT  mem [`HSD_BUFFER_DEPTH];
    logic                armStrobe;
    logic                capture;

    assign armStrobe = acqCsrWrite & wrData[0];
    assign capture   = (state == hsdPkg::ACQ_CAPTURE) & samplesValid;

    ////////////////////
    // Acquisition FSM
    always_ff @(posedge sysClk or negedge arstN) begin
        if (!arstN) begin
            state        <= hsdPkg::ACQ_IDLE;
            chanSel      <= '0;
            writeIdx     <= '0;
            acqTimestamp <= '0;
        end else begin
            if (acqCsrWrite) begin
                chanSel <= wrData[4 +: selWidth];
            end
            // Arming restarts from any state
            if (armStrobe) begin
                state    <= hsdPkg::ACQ_ARMED;
                writeIdx <= '0;
            end else begin
                case (state)
                    hsdPkg::ACQ_ARMED: begin
                        if (acqTrigger) begin
                            state        <= hsdPkg::ACQ_CAPTURE;
                            acqTimestamp <= microseconds;
                        end
                    end
                    hsdPkg::ACQ_CAPTURE: begin
                        if (samplesValid) begin
                            writeIdx <= writeIdx + 1'b1;
                            if (writeIdx == lastIndex) begin
                                state <= hsdPkg::ACQ_DONE;
                            end
                        end
                    end
                    default: begin
                        state <= state;
                    end
                endcase
            end
        end
    end

    ////////////////////
    // Sample memory
    always_ff @(posedge sysClk) begin
        if (capture) begin
            mem[writeIdx] <= samples[chanSel];
        end
    end

    // A pointer load arriving with a read sets the read address
    assign readAddr = acqDataWrite ? wrData[addrWidth-1:0] : readPtr;

    always_ff @(posedge sysClk or negedge arstN) begin
        if (!arstN) begin
            readPtr <= '0;
        end else if (acqDataRead) begin
            readPtr <= readAddr + 1'b1;
        end else if (acqDataWrite) begin
            readPtr <= readAddr;
        end
    end

    // Read data lands in the response cycle
    always_ff @(posedge sysClk) begin
        if (acqDataRead) begin
            acqData <= mem[readAddr];
        end
    end

    always_comb begin
        acqStatus                 = '0;
        acqStatus[1:0]            = state;
        acqStatus[4 +: selWidth]  = chanSel;
    end

endmodule

// File: verilog/hsdTop.sv
`timescale 1ns/100ps
`include "hsd_cfg.svh"

module hsdTop #(
    parameter int ticksPerMicrosecond   = `HSD_TICKS_PER_US,
    parameter int microsecondsPerSecond = `HSD_US_PER_SECOND
) (
    input  logic                          sysClk,
    input  logic                          arstN,
    input  logic                          regValid,
    output logic                          regReady,
    input  logic                          regWrite,
    input  hsdPkg::regAddrT               regAddr,
    input  hsdPkg::regWordT               regWdata,
    output logic                          rspValid,
    output hsdPkg::regWordT               rspData,
    input  hsdPkg::sampleWordT            samples [`HSD_CHANNEL_COUNT],
    input  logic                          samplesValid,
    input  logic [`HSD_TRIGGER_WIDTH-2:0] eventTriggers
);

    ////////////////////
    // Register strobes and readback
    logic            triggerWrite;
    logic            acqCsrWrite;
    logic            acqDataWrite;
    logic            acqDataRead;
    logic            rangeClearWrite;
    hsdPkg::regWordT wrData;
    hsdPkg::regWordT microseconds;
    hsdPkg::regWordT seconds;
    hsdPkg::regWordT triggerMask;
    hsdPkg::regWordT acqStatus;
    hsdPkg::regWordT acqData;
    hsdPkg::regWordT acqTimestamp;
    hsdPkg::regWordT rangeWords [`HSD_CHANNEL_COUNT];
    logic            acqTrigger;

    regBank regBank_i (.*);

    timeKeeper #(
        .ticksPerMicrosecond(ticksPerMicrosecond),
        .microsecondsPerSecond(microsecondsPerSecond)
    ) timeKeeper_i (
        .sysClk(sysClk),
        .arstN(arstN),
        .microseconds(microseconds),
        .seconds(seconds)
    );

    triggerSelect triggerSelect_i (.*);

    rangeCheck rangeCheck_i (.*);

    acqBuffer acqBuffer_i (.*);

endmodule

// File: bench/hsdBench_properties.sv
`timescale 1ns/100ps

module hsdBench_properties (
    input logic            sysClk,
    input logic            arstN,
    input logic            regValid,
    input logic            regReady,
    input logic            regWrite,
    input logic            rspValid,
    input logic            acqCsrWrite,
    input hsdPkg::regWordT wrData,
    input hsdPkg::regWordT acqStatus
);

    // Number of failed assertions
    int failCount = 0;

    logic readAccept;
    logic armStrobe;
    logic isDone;

    assign readAccept = regValid & regReady & ~regWrite;
    assign armStrobe  = acqCsrWrite & wrData[0];
    assign isDone     = (acqStatus[1:0] == hsdPkg::ACQ_DONE);

    ////////////////////
    // Host handshake
    readGetsResponse: assert property (
        @(posedge sysClk) disable iff (!arstN) readAccept |=> rspValid
    ) else begin
        failCount++;
        $error("rspValid did not follow an accepted read");
    end

    // A response only ever follows a read
    responseHasRead: assert property (
        @(posedge sysClk) disable iff (!arstN) rspValid |-> $past(readAccept)
    ) else begin
        failCount++;
        $error("rspValid rose without an accepted read the cycle before");
    end

    readyLowPending: assert property (
        @(posedge sysClk) disable iff (!arstN) rspValid |-> !regReady
    ) else begin
        failCount++;
        $error("regReady was high while a read response was pending");
    end

    // Reset values seen on the first edge after reset
    resetValues: assert property (
        @(posedge sysClk) !arstN |=> (!rspValid && regReady)
    ) else begin
        failCount++;
        $error("rspValid or regReady did not hold its reset value");
    end

    ////////////////////
    // Acquisition FSM
    doneHolds: assert property (
        @(posedge sysClk) disable iff (!arstN) (isDone && !armStrobe) |=> isDone
    ) else begin
        failCount++;
        $error("acquisition state left DONE without an arm strobe");
    end

endmodule

bind hsdTop hsdBench_properties hsdProps_i (.*);

// File: bench/hsdBench.sv
`timescale 1ns/100ps
`include "hsd_cfg.svh"

module hsdBench;

    localparam int chans     = `HSD_CHANNEL_COUNT;
    localparam int lanes     = `HSD_SAMPLES_PER_CLOCK;
    localparam int laneW     = `HSD_LANE_WIDTH;
    localparam int codeW     = `HSD_ADC_WIDTH;
    localparam int codeLsb   = `HSD_LANE_WIDTH - `HSD_ADC_WIDTH;
    localparam int depth     = `HSD_BUFFER_DEPTH;
    localparam int histDepth = 4096;
    localparam int maxWait   = 200;

    logic               sysClk;
    logic               arstN;
    logic               regValid;
    logic               regReady;
    logic               regWrite;
    hsdPkg::regAddrT    regAddr;
    hsdPkg::regWordT    regWdata;
    logic               rspValid;
    hsdPkg::regWordT    rspData;
    hsdPkg::sampleWordT samples [chans] = '{default: '0};
    logic               samplesValid = 1'b0;
    logic [5:0]         eventTriggers;

    // Stream control and reference model
    logic               streamOn;
    logic               injectOn;
    logic [31:0]        lfsrState = 32'ha8c5_1900;
    int                 wordCount = 0;
    hsdPkg::sampleWordT sentWords [chans][histDepth];
    int                 modelMin [chans] = '{default: 2047};
    int                 modelMax [chans] = '{default: -2048};
    int                 clearRequests = 0;
    int                 clearsSeen = 0;
    int                 cycleNum = 0;
    int                 errorCount = 0;
    int                 timeoutCount = 0;

    hsdTop #(
        .ticksPerMicrosecond(10),
        .microsecondsPerSecond(20)
    ) dut_i (.*);

    initial begin
        sysClk = 1'b0;
        forever #5 sysClk = ~sysClk;
    end

    always @(posedge sysClk) begin
        cycleNum <= cycleNum + 1;
    end

    ////////////////////
    // Helpers
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit
    function automatic logic [7:0] takeBits(input int n);
        logic [7:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);
            bits = {bits[6:0], lfsrState[0]};
        end
        return bits;
    endfunction

    function automatic logic [11:0] laneCode(input hsdPkg::sampleWordT w, input int lane);
        return w[lane*laneW + codeLsb +: codeW];
    endfunction

    // Every lane code moved on by n
    function automatic hsdPkg::sampleWordT shiftWord(input hsdPkg::sampleWordT w, input int n);
        hsdPkg::sampleWordT result;
        logic [11:0]        code;
        result = '0;
        for (int l = 0; l < lanes; l++) begin
            code = laneCode(w, l) + 12'(n);
            result[l*laneW + codeLsb +: codeW] = code;
        end
        return result;
    endfunction

    function automatic hsdPkg::regWordT rangeWord(input int maxV, input int minV);
        return {16'(maxV), 16'(minV)};
    endfunction

    ////////////////////
    // Sample stream
    always @(posedge sysClk) begin : streamDrive
        logic [11:0]        code;
        logic [7:0]         pick;
        hsdPkg::sampleWordT word;
        #1;
        if (clearsSeen != clearRequests) begin
            clearsSeen = clearRequests;
            for (int ch = 0; ch < chans; ch++) begin
                modelMin[ch] = 2047;
                modelMax[ch] = -2048;
            end
        end
        if (streamOn) begin
            pick = takeBits(1);
            samplesValid = pick[0];
            if (samplesValid) begin
                // Top three bits select roughly one word in eight for an extreme code
                pick = injectOn ? takeBits(6) : 8'h00;
                for (int ch = 0; ch < chans; ch++) begin
                    word = '0;
                    for (int l = 0; l < lanes; l++) begin
                        code = 12'(wordCount + l - ch * 1500);
                        if (pick[5:3] == 3'b111 && pick[2] == ch[0] && pick[1] == l[0]) begin
                            code = pick[0] ? 12'h7ff : 12'h800;
                        end
                        word[l*laneW + codeLsb +: codeW] = code;
                        if ($signed(code) < modelMin[ch]) begin
                            modelMin[ch] = $signed(code);
                        end
                        if ($signed(code) > modelMax[ch]) begin
                            modelMax[ch] = $signed(code);
                        end
                    end
                    samples[ch] = word;
                    if (wordCount < histDepth) begin
                        sentWords[ch][wordCount] = word;
                    end
                end
                wordCount++;
            end
        end else begin
            samplesValid = 1'b0;
        end
    end

    ////////////////////
    // Host access
    task automatic waitReady(input hsdPkg::regAddrT addr);
        int waitCount;
        waitCount = 0;
        while (!regReady && waitCount < maxWait) begin
            @(posedge sysClk);
            #1;
            waitCount++;
        end
        if (!regReady) begin
            $display("Timeout at %0t: regReady never rose for address %0d", $time, addr);
            timeoutCount++;
        end
    endtask

    task automatic writeReg(input hsdPkg::regAddrT addr, input hsdPkg::regWordT data);
        regValid = 1'b1;
        regWrite = 1'b1;
        regAddr  = addr;
        regWdata = data;
        waitReady(addr);
        @(posedge sysClk);
        #1;
        regValid = 1'b0;
        regWrite = 1'b0;
    endtask

    task automatic readReg(input hsdPkg::regAddrT addr, output hsdPkg::regWordT data);
        int waitCount;
        regValid = 1'b1;
        regWrite = 1'b0;
        regAddr  = addr;
        waitReady(addr);
        @(posedge sysClk);
        #1;
        regValid = 1'b0;
        waitCount = 0;
        while (!rspValid && waitCount < maxWait) begin
            @(posedge sysClk);
            #1;
            waitCount++;
        end
        if (!rspValid) begin
            $display("Timeout at %0t: no read response for address %0d", $time, addr);
            timeoutCount++;
        end
        data = rspData;
    endtask

    task automatic checkValue(input string name, input hsdPkg::regWordT expected,
                              input hsdPkg::regWordT actual);
        assert (actual == expected) else begin
            $display("MISMATCH at %0t: %s expected 0x%08h actual 0x%08h",
                     $time, name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkWithin(input string name, input int lo, input int hi, input int actual);
        assert (actual >= lo && actual <= hi) else begin
            $display("MISMATCH at %0t: %s expected %0d to %0d actual %0d",
                     $time, name, lo, hi, actual);
            errorCount++;
        end
    endtask

    task automatic waitState(input logic [1:0] target);
        hsdPkg::regWordT csr;
        int              polls;
        polls = 0;
        readReg(`HSD_REG_ACQ_CSR, csr);
        while (csr[1:0] != target && polls < 500) begin
            readReg(`HSD_REG_ACQ_CSR, csr);
            polls++;
        end
        if (csr[1:0] != target) begin
            $display("Timeout at %0t: acquisition state never reached %0d", $time, target);
            timeoutCount++;
        end
    endtask

    // Full readout, word 0 must come from the channel and lanes count up
    task automatic readCapture(input int ch);
        hsdPkg::regWordT word;
        hsdPkg::regWordT prev;
        bit              found;
        writeReg(`HSD_REG_ACQ_DATA, 32'd0);
        for (int i = 0; i < depth; i++) begin
            readReg(`HSD_REG_ACQ_DATA, word);
            if (i == 0) begin
                found = 1'b0;
                for (int k = 0; k < wordCount && k < histDepth; k++) begin
                    if (sentWords[ch][k] == word) begin
                        found = 1'b1;
                    end
                end
                assert (found) else begin
                    $display("Captured word 0x%08h was never sent on channel %0d", word, ch);
                    errorCount++;
                end
            end else begin
                checkValue($sformatf("rspData word %0d", i), shiftWord(prev, 1), word);
            end
            prev = word;
        end
    endtask

    ////////////////////
    // Test sequence
    initial begin : mainFlow
        hsdPkg::regWordT value;
        hsdPkg::regWordT usBefore;
        hsdPkg::regWordT usAfter;
        hsdPkg::regWordT word0;
        int              cycleBefore;
        int              failures;
        arstN         = 1'b0;
        regValid      = 1'b0;
        regWrite      = 1'b0;
        regAddr       = '0;
        regWdata      = '0;
        eventTriggers = '0;
        streamOn      = 1'b0;
        injectOn      = 1'b0;
        repeat (5) @(posedge sysClk);
        #1;
        arstN    = 1'b1;
        streamOn = 1'b1;

        // ID, unused address and reset values
        readReg(`HSD_REG_ID, value);
        checkValue("rspData ID", `HSD_FIRMWARE_ID, value);
        readReg(5'd20, value);
        checkValue("rspData unused", 32'd0, value);
        readReg(`HSD_REG_ACQ_CSR, value);
        checkValue("rspData ACQ_CSR", 32'd0, value);
        readReg(`HSD_REG_TRIGGER, value);
        checkValue("rspData TRIGGER", 32'd0, value);

        // Time since boot, 10 cycles per microsecond
        readReg(`HSD_REG_MICROSECONDS, usBefore);
        cycleBefore = cycleNum;
        repeat (400) @(posedge sysClk);
        #1;
        readReg(`HSD_REG_MICROSECONDS, usAfter);
        checkWithin("microseconds delta", (cycleNum - cycleBefore) / 10 - 1,
                    (cycleNum - cycleBefore) / 10 + 1, int'(usAfter - usBefore));
        readReg(`HSD_REG_MICROSECONDS, usAfter);
        readReg(`HSD_REG_SECONDS, value);
        checkWithin("seconds", int'(usAfter) / 20 - 1, int'(usAfter) / 20 + 1, int'(value));

        // Software trigger on channel 0, event bit 3 masked off
        writeReg(`HSD_REG_TRIGGER, 32'h2);
        // Mask loads on the edge after the write is accepted
        @(posedge sysClk);
        #1;
        readReg(`HSD_REG_TRIGGER, value);
        checkValue("rspData TRIGGER", 32'h2, value);
        writeReg(`HSD_REG_ACQ_CSR, 32'h1);
        eventTriggers[3] = 1'b1;
        repeat (4) @(posedge sysClk);
        #1;
        eventTriggers[3] = 1'b0;
        repeat (8) @(posedge sysClk);
        #1;
        readReg(`HSD_REG_ACQ_CSR, value);
        checkValue("rspData ACQ_CSR armed", 32'h1, value);
        readReg(`HSD_REG_MICROSECONDS, usBefore);
        writeReg(`HSD_REG_TRIGGER, 32'h3);
        // Timestamp latched two edges after the write is accepted
        @(posedge sysClk);
        #1;
        readReg(`HSD_REG_MICROSECONDS, usAfter);
        waitState(2'd3);
        readReg(`HSD_REG_ACQ_TIMESTAMP, value);
        checkWithin("acqTimestamp", int'(usBefore), int'(usAfter), int'(value));
        readCapture(0);

        // Event bit 3 on channel 1
        writeReg(`HSD_REG_TRIGGER, 32'h20);
        writeReg(`HSD_REG_ACQ_CSR, 32'h11);
        @(posedge sysClk);
        #1;
        readReg(`HSD_REG_ACQ_CSR, value);
        checkValue("rspData ACQ_CSR armed", 32'h11, value);
        eventTriggers[3] = 1'b1;
        waitState(2'd3);
        eventTriggers[3] = 1'b0;
        readCapture(1);
        writeReg(`HSD_REG_ACQ_DATA, 32'd0);
        readReg(`HSD_REG_ACQ_DATA, word0);
        writeReg(`HSD_REG_ACQ_DATA, 32'd10);
        readReg(`HSD_REG_ACQ_DATA, value);
        checkValue("rspData word 10", shiftWord(word0, 10), value);

        // Range monitor with injected extremes
        streamOn = 1'b0;
        repeat (4) @(posedge sysClk);
        #1;
        writeReg(`HSD_REG_RANGE_CLEAR, 32'd0);
        clearRequests++;
        repeat (2) @(posedge sysClk);
        #1;
        readReg(`HSD_REG_RANGE_BASE, value);
        checkValue("rangeWords cleared", rangeWord(-2048, 2047), value);
        injectOn = 1'b1;
        streamOn = 1'b1;
        repeat (300) @(posedge sysClk);
        #1;
        streamOn = 1'b0;
        injectOn = 1'b0;
        repeat (4) @(posedge sysClk);
        #1;
        for (int ch = 0; ch < chans; ch++) begin
            readReg(hsdPkg::regAddrT'(`HSD_REG_RANGE_BASE + ch), value);
            checkValue($sformatf("rangeWords[%0d]", ch), rangeWord(modelMax[ch], modelMin[ch]),
                       value);
        end

        failures = errorCount + timeoutCount + dut_i.hsdProps_i.failCount;
        $display("Checks complete: %0d mismatches, %0d timeouts, %0d assertion failures",
                 errorCount, timeoutCount, dut_i.hsdProps_i.failCount);
        if (failures == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+verilog
verilog/hsdPkg.sv
verilog/regBank.sv
verilog/timeKeeper.sv
verilog/triggerSelect.sv
verilog/rangeCheck.sv
verilog/acqBuffer.sv
verilog/hsdTop.sv
bench/hsdBench_properties.sv
bench/hsdBench.sv
